// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dma_rd_req
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_TEXT ?= TESTBENCH PASSED

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard hw/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
+incdir+hw
hw/tlp_pkg.sv
hw/dma_pkg.sv
hw/np_hdr_if.sv
hw/tag_allocator.sv
hw/non_posted_pkt_builder.sv
hw/rd_tag_table.sv
hw/hdr_fifo.sv
hw/dma_rd_req_top.sv
test/tb_dma_rd_req.sv

// ==== hw/dma_pkg.sv ====
`default_nettype none

`include "np_defines.svh"

package dma_pkg;

  typedef struct packed {
    logic [63:0] addr;
    logic [31:0] dest;
    logic [9:0]  len;
    logic        is_des;
  } rd_req_t;

  // Context returned with the completion
  typedef struct packed {
    logic                      is_des;
    logic [`NP_DEST_BLK_W-1:0] dest_blk;
  } rd_ctx_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_TAG,
    ST_HDR0,
    ST_HDR1,
    ST_DONE
  } np_state_e;

endpackage

`default_nettype wire

// ==== hw/dma_rd_req_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "np_defines.svh"

module dma_rd_req_top (
  input  wire logic                 clk,
  input  wire logic                 rst_reg,
  input  wire logic [15:0]          req_id,
  input  wire logic                 req_valid,
  output logic                      req_ready,
  input  wire logic [63:0]          req_addr,
  input  wire logic [31:0]          req_dest,
  input  wire logic [9:0]           req_len,
  input  wire logic                 req_is_des,
  output tlp_pkg::tlp_hdr_word_t    hdr_data,
  output logic                      hdr_valid,
  input  wire logic                 hdr_ready,
  output logic                      hdr_last,
  input  wire logic                 cpl_valid,
  input  wire logic [`NP_TAG_W-1:0] cpl_tag,
  output logic                      cpl_info_valid,
  output logic [`NP_TAG_W-1:0]      cpl_info_tag,
  output logic                      cpl_info_is_des,
  output logic [`NP_DEST_BLK_W-1:0] cpl_info_dest_blk
);

  dma_pkg::rd_req_t       req;
  dma_pkg::rd_ctx_t       tbl_ctx;
  dma_pkg::rd_ctx_t       info_ctx;
  logic                   tag_avail;
  logic [`NP_TAG_W-1:0]   free_tag;
  logic                   tag_take;
  logic                   tbl_we;
  logic [`NP_TAG_W-1:0]   tbl_tag;
  logic                   rel_valid;
  logic [`NP_TAG_W-1:0]   rel_tag;

  np_hdr_if hdr_bus ();

  assign req = '{addr: req_addr, dest: req_dest, len: req_len, is_des: req_is_des};
  assign cpl_info_is_des = info_ctx.is_des;
  assign cpl_info_dest_blk = info_ctx.dest_blk;

  tag_allocator u_tag_alloc (
    .clk, .rst_reg, .take(tag_take), .rel_valid, .rel_tag, .tag_avail, .free_tag
  );

  non_posted_pkt_builder u_builder (
    .clk, .rst_reg, .req_id, .req, .req_valid, .req_ready, .tag_avail, .free_tag,
    .tag_take, .tbl_we, .tbl_tag, .tbl_ctx, .hdr(hdr_bus.builder)
  );

  rd_tag_table u_tag_table (
    .clk, .rst_reg, .we(tbl_we), .wtag(tbl_tag), .wctx(tbl_ctx), .cpl_valid, .cpl_tag,
    .info_valid(cpl_info_valid), .info_tag(cpl_info_tag), .info_ctx, .rel_valid, .rel_tag
  );

  hdr_fifo #(.DEPTH(`NP_HDR_FIFO_DEPTH)) u_hdr_fifo (
    .clk, .rst_reg, .in(hdr_bus.sink), .out_data(hdr_data), .out_last(hdr_last),
    .out_valid(hdr_valid), .out_ready(hdr_ready)
  );

endmodule

`default_nettype wire

// ==== hw/hdr_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "np_defines.svh"

module hdr_fifo #(
  parameter int DEPTH = `NP_HDR_FIFO_DEPTH
) (
  input  wire logic              clk,
  input  wire logic              rst_reg,
  np_hdr_if.sink                 in,
  output tlp_pkg::tlp_hdr_word_t out_data,
  output logic                   out_last,
  output logic                   out_valid,
  input  wire logic              out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  tlp_pkg::tlp_hdr_word_t mem_data [DEPTH];
  logic                   mem_last [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;
  logic                   full;
  logic                   push;
  logic                   pop;

  assign full = (count == CNT_W'(DEPTH));
  assign in.ready = !full;
  assign out_valid = (count != '0);
  assign out_data = mem_data[rd_ptr];
  assign out_last = mem_last[rd_ptr];
  assign push = in.valid && !full;
  assign pop = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr] <= in.data;
      mem_last[wr_ptr] <= in.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  a_no_wr_full: assert property (@(posedge clk) disable iff (rst_reg)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
    else $error("header FIFO overwrote its head word while stalled");

endmodule

`default_nettype wire

// ==== hw/non_posted_pkt_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "np_defines.svh"

module non_posted_pkt_builder (
  input  wire logic                 clk,
  input  wire logic                 rst_reg,
  input  wire logic [15:0]          req_id,
  input  wire dma_pkg::rd_req_t     req,
  input  wire logic                 req_valid,
  output logic                      req_ready,
  input  wire logic                 tag_avail,
  input  wire logic [`NP_TAG_W-1:0] free_tag,
  output logic                      tag_take,
  output logic                      tbl_we,
  output logic [`NP_TAG_W-1:0]      tbl_tag,
  output dma_pkg::rd_ctx_t          tbl_ctx,
  np_hdr_if.builder                 hdr
);

  localparam int TAG_W = `NP_TAG_W;

  // Fixed header fields
  localparam logic [2:0] TC = 3'b000;
  localparam logic       TD = 1'b0;
  localparam logic       EP = 1'b0;
  localparam logic [1:0] ATTR = 2'b00;
  localparam logic [3:0] LAST_BE = 4'hf;
  localparam logic [3:0] FIRST_BE = 4'hf;

  dma_pkg::np_state_e     state;
  dma_pkg::rd_req_t       req_q;
  logic [TAG_W-1:0]       tag_q;
  logic [7:0]             tag_field;
  tlp_pkg::tlp_fmt_e      fmt;
  tlp_pkg::tlp_hdr_word_t word0;
  tlp_pkg::tlp_hdr_word_t word1;

  // 3DW form whenever the upper address half is zero
  assign fmt = (req_q.addr[63:32] == 32'h0) ? tlp_pkg::FMT_3DW_NODATA
                                            : tlp_pkg::FMT_4DW_NODATA;
  assign tag_field = {{(8 - TAG_W){1'b0}}, tag_q};

  assign word0 = {1'b0, fmt, tlp_pkg::TLP_MRD, 1'b0, TC, 4'b0000, TD, EP, ATTR,
                  2'b00, req_q.len, req_id, tag_field, LAST_BE, FIRST_BE};
  assign word1 = (fmt == tlp_pkg::FMT_4DW_NODATA)
               ? {req_q.addr[63:2], 2'b00}
               : {req_q.addr[31:2], 2'b00, req_q.addr[63:32]};

  assign req_ready = (state == dma_pkg::ST_IDLE);

  assign hdr.valid = (state == dma_pkg::ST_HDR0) || (state == dma_pkg::ST_HDR1);
  assign hdr.last = (state == dma_pkg::ST_HDR1);
  assign hdr.data = (state == dma_pkg::ST_HDR1) ? word1 : word0;

  // Tag claim and context write on the last header beat
  assign tag_take = (state == dma_pkg::ST_HDR1) && hdr.ready;
  assign tbl_we = tag_take;
  assign tbl_tag = tag_q;
  assign tbl_ctx = '{is_des: req_q.is_des,
                     dest_blk: req_q.dest[`NP_DEST_BLK_LSB +: `NP_DEST_BLK_W]};

  always_ff @(posedge clk) begin
    if (state == dma_pkg::ST_IDLE && req_valid) req_q <= req;
    if (state == dma_pkg::ST_WAIT_TAG && tag_avail) tag_q <= free_tag;
  end

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      state <= dma_pkg::ST_IDLE;
    end else begin
      case (state)
        dma_pkg::ST_IDLE: if (req_valid) state <= dma_pkg::ST_WAIT_TAG;
        dma_pkg::ST_WAIT_TAG: if (tag_avail) state <= dma_pkg::ST_HDR0;
        dma_pkg::ST_HDR0: if (hdr.ready) state <= dma_pkg::ST_HDR1;
        dma_pkg::ST_HDR1: if (hdr.ready) state <= dma_pkg::ST_DONE;
        // Lets the allocator settle its registered free tag
        dma_pkg::ST_DONE: state <= dma_pkg::ST_IDLE;
        default: state <= dma_pkg::ST_IDLE;
      endcase
    end
  end

  a_hdr_hold: assert property (@(posedge clk) disable iff (rst_reg)
    (hdr.valid && !hdr.ready) |=> (hdr.valid && $stable(hdr.data) && $stable(hdr.last)))
    else $error("header word changed while stalled");

endmodule

`default_nettype wire

// ==== hw/np_defines.svh ====
`ifndef NP_DEFINES_SVH
`define NP_DEFINES_SVH

// Tag space for outstanding non-posted reads
`define NP_TAG_W 5
`define NP_TAG_COUNT 32

// Destination block kept per tag, destination bits 27 to 6
`define NP_DEST_BLK_W 22
`define NP_DEST_BLK_LSB 6

// Header words buffered between builder and TX port
`define NP_HDR_FIFO_DEPTH 2

`endif

// ==== hw/np_hdr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface np_hdr_if;

  tlp_pkg::tlp_hdr_word_t data;
  logic                   valid;
  logic                   ready;
  logic                   last;

  modport builder (output data, output valid, output last, input ready);

  modport sink (input data, input valid, input last, output ready);

endinterface

`default_nettype wire

// ==== hw/rd_tag_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "np_defines.svh"

module rd_tag_table (
  input  wire logic                 clk,
  input  wire logic                 rst_reg,
  input  wire logic                 we,
  input  wire logic [`NP_TAG_W-1:0] wtag,
  input  wire dma_pkg::rd_ctx_t     wctx,
  input  wire logic                 cpl_valid,
  input  wire logic [`NP_TAG_W-1:0] cpl_tag,
  output logic                      info_valid,
  output logic [`NP_TAG_W-1:0]      info_tag,
  output dma_pkg::rd_ctx_t          info_ctx,
  output logic                      rel_valid,
  output logic [`NP_TAG_W-1:0]      rel_tag
);

  dma_pkg::rd_ctx_t ctx_mem [`NP_TAG_COUNT];

  always_ff @(posedge clk) begin
    if (we) ctx_mem[wtag] <= wctx;
  end

  // Registered lookup, answer one cycle after the completion
  always_ff @(posedge clk) begin
    if (cpl_valid) begin
      info_tag <= cpl_tag;
      info_ctx <= ctx_mem[cpl_tag];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_reg) info_valid <= 1'b0;
    else info_valid <= cpl_valid;
  end

  // Tag goes back to the pool while the answer is presented
  assign rel_valid = info_valid;
  assign rel_tag = info_tag;

endmodule

`default_nettype wire

// ==== hw/tag_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "np_defines.svh"

module tag_allocator (
  input  wire logic                 clk,
  input  wire logic                 rst_reg,
  input  wire logic                 take,
  input  wire logic                 rel_valid,
  input  wire logic [`NP_TAG_W-1:0] rel_tag,
  output logic                      tag_avail,
  output logic [`NP_TAG_W-1:0]      free_tag
);

  localparam int TAG_W = `NP_TAG_W;
  localparam int TAG_COUNT = `NP_TAG_COUNT;

  logic [TAG_COUNT-1:0] free_map;
  logic                 next_avail;
  logic [TAG_W-1:0]     next_tag;

  // Lowest set bit wins
  always_comb begin
    next_avail = 1'b0;
    next_tag = '0;
    for (int i = TAG_COUNT - 1; i >= 0; i--) begin
      if (free_map[i]) begin
        next_avail = 1'b1;
        next_tag = TAG_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      free_map <= '1;
      tag_avail <= 1'b1;
      free_tag <= '0;
    end else begin
      if (take) free_map[free_tag] <= 1'b0;
      if (rel_valid) free_map[rel_tag] <= 1'b1;
      tag_avail <= next_avail;
      free_tag <= next_tag;
    end
  end

  a_rel_busy: assert property (@(posedge clk) disable iff (rst_reg)
    rel_valid |-> !free_map[rel_tag])
    else $error("release of a tag that is already free");

  a_take_avail: assert property (@(posedge clk) disable iff (rst_reg)
    take |-> tag_avail)
    else $error("tag taken while none available");

endmodule

`default_nettype wire

// ==== hw/tlp_pkg.sv ====
`default_nettype none

package tlp_pkg;

  // Fmt field for the header-only (no data) requests issued here
  typedef enum logic [1:0] {
    FMT_3DW_NODATA = 2'b00,
    FMT_4DW_NODATA = 2'b01
  } tlp_fmt_e;

  // Type field, completion listed for decode on the RX side
  typedef enum logic [4:0] {
    TLP_MRD = 5'b00000,
    TLP_CPL = 5'b01010
  } tlp_type_e;

  // One 64-bit header beat, two beats per request
  typedef logic [63:0] tlp_hdr_word_t;

endpackage

`default_nettype wire

// ==== test/tb_dma_rd_req.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "np_defines.svh"

module tb_dma_rd_req;

  typedef logic [1:0][63:0] hdr_pair_t;

  localparam int TAG_W = `NP_TAG_W;
  localparam int TAGS = `NP_TAG_COUNT;
  localparam int WAIT_LIMIT = 1000;

  logic                      clk;
  logic                      rst_reg;
  logic [15:0]               req_id;
  logic                      req_valid;
  logic                      req_ready;
  logic [63:0]               req_addr;
  logic [31:0]               req_dest;
  logic [9:0]                req_len;
  logic                      req_is_des;
  tlp_pkg::tlp_hdr_word_t    hdr_data;
  logic                      hdr_valid;
  logic                      hdr_ready;
  logic                      hdr_last;
  logic                      cpl_valid;
  logic [TAG_W-1:0]          cpl_tag;
  logic                      cpl_info_valid;
  logic [TAG_W-1:0]          cpl_info_tag;
  logic                      cpl_info_is_des;
  logic [`NP_DEST_BLK_W-1:0] cpl_info_dest_blk;

  // Scoreboard state and tag model
  tlp_pkg::tlp_hdr_word_t exp_words[$];
  bit                     exp_last[$];
  bit                     tag_busy [TAGS];
  dma_pkg::rd_ctx_t       ctx_map [TAGS];
  int                     err_count = 0;
  int                     timeout_count = 0;
  bit                     bp_on = 1'b0;

  dma_rd_req_top dut (.*);

  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reference header per the Memory Read layout
  function automatic hdr_pair_t expected_hdr(input dma_pkg::rd_req_t r, input logic [15:0] rid,
                                             input logic [TAG_W-1:0] tag);
    hdr_pair_t         words;
    tlp_pkg::tlp_fmt_e fmt;
    fmt = (r.addr[63:32] == 32'h0) ? tlp_pkg::FMT_3DW_NODATA : tlp_pkg::FMT_4DW_NODATA;
    words = '0;
    words[0][62:61] = fmt;
    words[0][60:56] = tlp_pkg::TLP_MRD;
    words[0][41:32] = r.len;
    words[0][31:16] = rid;
    words[0][8 +: TAG_W] = tag;
    words[0][7:0] = 8'hff;
    if (fmt == tlp_pkg::FMT_4DW_NODATA) words[1] = r.addr & ~64'h3;
    else words[1] = {r.addr[31:0] & 32'hffff_fffc, 32'h0};
    return words;
  endfunction

  function automatic int lowest_free();
    for (int i = 0; i < TAGS; i++) begin
      if (!tag_busy[i]) return i;
    end
    return -1;
  endfunction

  function automatic dma_pkg::rd_req_t make_req(input bit four_dw);
    dma_pkg::rd_req_t r;
    r.addr[31:0] = $urandom;
    r.addr[63:32] = four_dw ? ($urandom | 32'h1) : 32'h0;
    r.dest = $urandom;
    r.len = 10'($urandom);
    r.is_des = 1'($urandom);
    return r;
  endfunction

  task automatic check_hdr(input string name, input tlp_pkg::tlp_hdr_word_t got,
                           input tlp_pkg::tlp_hdr_word_t exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_ctx(input string name, input dma_pkg::rd_ctx_t got,
                           input dma_pkg::rd_ctx_t exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Checks done with %0d mismatches and %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    timeout_count++;
    $display("Timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic claim_tag(input dma_pkg::rd_req_t r, input int t);
    hdr_pair_t words;
    words = expected_hdr(r, req_id, TAG_W'(t));
    tag_busy[t] = 1'b1;
    ctx_map[t].is_des = r.is_des;
    ctx_map[t].dest_blk = r.dest[27:6];
    exp_words.push_back(words[0]);
    exp_last.push_back(1'b0);
    exp_words.push_back(words[1]);
    exp_last.push_back(1'b1);
  endtask

  task automatic send_req(input dma_pkg::rd_req_t r);
    int waited;
    waited = 0;
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr <= r.addr;
    req_dest <= r.dest;
    req_len <= r.len;
    req_is_des <= r.is_des;
    @(negedge clk);
    while (!req_ready) begin
      if (waited == WAIT_LIMIT) abort_run("req_ready");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic issue_req(input dma_pkg::rd_req_t r);
    int t;
    t = lowest_free();
    if (t < 0) begin
      err_count++;
      $display("No free tag left in the model for a new request");
    end else begin
      claim_tag(r, t);
      send_req(r);
    end
  endtask

  task automatic drain_headers();
    int waited;
    waited = 0;
    while (exp_words.size() != 0) begin
      if (waited == WAIT_LIMIT) abort_run("the expected header words");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // Answer is due exactly one cycle after the completion is sampled
  task automatic complete_tag(input int t);
    dma_pkg::rd_ctx_t got;
    @(posedge clk);
    cpl_valid <= 1'b1;
    cpl_tag <= TAG_W'(t);
    @(negedge clk);
    check_field("cpl_info_valid", 32'(cpl_info_valid), 0);
    @(posedge clk);
    cpl_valid <= 1'b0;
    @(negedge clk);
    check_field("cpl_info_valid", 32'(cpl_info_valid), 1);
    check_field("cpl_info_tag", 32'(cpl_info_tag), t);
    got.is_des = cpl_info_is_des;
    got.dest_blk = cpl_info_dest_blk;
    check_ctx("cpl_info_ctx", got, ctx_map[t]);
    tag_busy[t] = 1'b0;
    // Free tag register needs two edges to reflect the release
    repeat (2) @(posedge clk);
  endtask

  initial begin : ready_driver
    forever begin
      @(posedge clk);
      if (bp_on) hdr_ready <= ($urandom % 4) != 0;
      else hdr_ready <= 1'b1;
    end
  end

  initial begin : hdr_checker
    forever begin
      @(negedge clk);
      if (!rst_reg && hdr_valid && hdr_ready) begin
        if (exp_words.size() == 0) begin
          err_count++;
          $display("Header word %h left the DUT while none was expected", hdr_data);
        end else begin
          check_hdr("hdr_data", hdr_data, exp_words.pop_front());
          check_field("hdr_last", 32'(hdr_last), 32'(exp_last.pop_front()));
        end
      end
    end
  end

  initial begin : main_flow
    dma_pkg::rd_req_t blocked;
    int               t;
    void'($urandom(22));
    rst_reg = 1'b1;
    req_id = 16'($urandom);
    req_valid = 1'b0;
    req_addr = '0;
    req_dest = '0;
    req_len = '0;
    req_is_des = 1'b0;
    hdr_ready = 1'b1;
    cpl_valid = 1'b0;
    cpl_tag = '0;
    repeat (2) @(posedge clk);
    rst_reg <= 1'b0;
    @(negedge clk);
    check_field("req_ready", 32'(req_ready), 1);
    check_field("hdr_valid", 32'(hdr_valid), 0);
    check_field("cpl_info_valid", 32'(cpl_info_valid), 0);

    repeat (4) issue_req(make_req(1'b0));
    repeat (4) issue_req(make_req(1'b1));
    drain_headers();
    for (int i = 7; i >= 0; i--) complete_tag(i);

    // All tags outstanding, with random back-pressure on the header port
    bp_on = 1'b1;
    for (int i = 0; i < TAGS; i++) issue_req(make_req(1'($urandom)));
    drain_headers();

    blocked = make_req(1'($urandom));
    send_req(blocked);
    repeat (30) begin
      @(negedge clk);
      check_field("hdr_valid", 32'(hdr_valid), 0);
    end
    t = 3 + int'($urandom % 25);
    complete_tag(t);
    claim_tag(blocked, lowest_free());
    drain_headers();

    for (int i = 0; i < TAGS; i++) complete_tag(i);
    bp_on = 1'b0;
    repeat (3) issue_req(make_req(1'($urandom)));
    drain_headers();
    finish_run();
  end

endmodule

`default_nettype wire
